//--- execute.sv
`timescale 1ns/10ps

module execute import exu_pkg::*; (
  input  logic              clock,
  input  logic              arst_n_i,

  input  logic              valid_pre_i,
  output logic              ready_pre_o,
  input  exu_req_t          req_i,

  output logic              valid_post_o,
  input  logic              ready_post_i,
  output exu_res_t          res_o,

  // AW
  output logic              awvalid_o,
  input  logic              awready_i,
  output logic [xlen-1:0]   awaddr_o,

  // W
  output logic              wvalid_o,
  input  logic              wready_i,
  output logic [xlen-1:0]   wdata_o,
  output logic [strb_w-1:0] wstrb_o,
  output logic              wlast_o,

  // B
  input  logic              bvalid_i,
  output logic              bready_o,
  input  logic [resp_w-1:0] bresp_i,

  // AR
  output logic              arvalid_o,
  input  logic              arready_i,
  output logic [xlen-1:0]   araddr_o,

  // R
  input  logic              rvalid_i,
  output logic              rready_o,
  input  logic [xlen-1:0]   rdata_i,
  input  logic [resp_w-1:0] rresp_i,
  input  logic              rlast_i
);

  logic            we;
  logic            rdata_we;
  exu_req_t        q;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] csr_wdata;
  logic [xlen-1:0] mem_result;

  execute_controller controller (
    .clock        ( clock        ),
    .arst_n_i     ( arst_n_i     ),
    .valid_pre_i  ( valid_pre_i  ),
    .ready_pre_o  ( ready_pre_o  ),
    .valid_post_o ( valid_post_o ),
    .ready_post_i ( ready_post_i ),
    .inst_type_i  ( q.inst_type  ),
    .we_o         ( we           ),
    .rdata_we_o   ( rdata_we     ),
    .awready_i    ( awready_i    ),
    .awvalid_o    ( awvalid_o    ),
    .wready_i     ( wready_i     ),
    .wvalid_o     ( wvalid_o     ),
    .bvalid_i     ( bvalid_i     ),
    .bready_o     ( bready_o     ),
    .arready_i    ( arready_i    ),
    .arvalid_o    ( arvalid_o    ),
    .rvalid_i     ( rvalid_i     ),
    .rready_o     ( rready_o     )
  );

  execute_reg reg0 (
    .clock    ( clock    ),
    .arst_n_i ( arst_n_i ),
    .we_i     ( we       ),
    .req_i    ( req_i    ),
    .q_o      ( q        )
  );

  fu fu0 (
    .req_i        ( q          ),
    .alu_result_o ( alu_result ),
    .csr_wdata_o  ( csr_wdata  )
  );

  lsu lsu0 (
    .clock        ( clock      ),
    .arst_n_i     ( arst_n_i   ),
    .rdata_we_i   ( rdata_we   ),
    .req_i        ( q          ),
    .awaddr_o     ( awaddr_o   ),
    .araddr_o     ( araddr_o   ),
    .wdata_o      ( wdata_o    ),
    .wstrb_o      ( wstrb_o    ),
    .wlast_o      ( wlast_o    ),
    .rdata_i      ( rdata_i    ),
    .mem_result_o ( mem_result )
  );

  // Write-back bundle
  assign res_o = '{
    wsel:       q.wsel,
    wena:       q.wena,
    waddr:      q.waddr,
    alu_result: alu_result,
    mem_result: mem_result,
    csr_op:     q.csr_op,
    csr_wena:   q.csr_wena,
    csr_waddr:  q.csr_waddr,
    csr_wdata:  csr_wdata
  };

endmodule

//--- execute_controller.sv
`timescale 1ns/10ps

module execute_controller import exu_pkg::*; (
  input  logic       clock,
  input  logic       arst_n_i,

  input  logic       valid_pre_i,
  output logic       ready_pre_o,
  output logic       valid_post_o,
  input  logic       ready_post_i,

  input  inst_type_e inst_type_i,

  output logic       we_o,
  output logic       rdata_we_o,

  input  logic       awready_i,
  output logic       awvalid_o,
  input  logic       wready_i,
  output logic       wvalid_o,
  input  logic       bvalid_i,
  output logic       bready_o,
  input  logic       arready_i,
  output logic       arvalid_o,
  input  logic       rvalid_i,
  output logic       rready_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_exec,
    st_ar,
    st_r,
    st_aw_w,
    st_b,
    st_done
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   aw_done_q;
  logic   aw_done_d;
  logic   w_done_q;
  logic   w_done_d;
  logic   is_load;
  logic   is_store;
  logic   in_aw_w;
  logic   aw_ok;
  logic   w_ok;
  logic   post_xfer;

  assign is_load  = (inst_type_i == inst_load);
  assign is_store = (inst_type_i == inst_store);

  // AW and W are raised together and drop on their own acceptance
  assign in_aw_w   = (state_q == st_exec && is_store) || (state_q == st_aw_w);
  assign awvalid_o = in_aw_w && !aw_done_q;
  assign wvalid_o  = in_aw_w && !w_done_q;
  assign aw_ok     = aw_done_q || awready_i;
  assign w_ok      = w_done_q || wready_i;

  assign arvalid_o = (state_q == st_exec && is_load) || (state_q == st_ar);
  assign rready_o  = (state_q == st_r);
  assign bready_o  = (state_q == st_b);

  assign valid_post_o = (state_q == st_exec && !is_load && !is_store) ||
                        (state_q == st_done);
  assign post_xfer    = valid_post_o && ready_post_i;
  assign ready_pre_o  = (state_q == st_idle) || post_xfer;
  assign we_o         = valid_pre_i && ready_pre_o;
  assign rdata_we_o   = rready_o && rvalid_i;

  always_comb begin
    state_d   = state_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    case (state_q)
      st_idle: if (we_o) state_d = st_exec;
      st_exec: begin
        if (is_load) begin
          state_d = arready_i ? st_r : st_ar;
        end else if (!is_store) begin
          if (post_xfer) state_d = we_o ? st_exec : st_idle;
          else state_d = st_done;
        end
      end
      st_ar:   if (arready_i) state_d = st_r;
      st_r:    if (rvalid_i) state_d = st_done;
      st_b:    if (bvalid_i) state_d = st_done;
      st_done: if (post_xfer) state_d = we_o ? st_exec : st_idle;
      st_aw_w: ;
      default: state_d = st_idle;
    endcase
    // Store address and data phase, either channel may finish first
    if (in_aw_w) begin
      if (aw_ok && w_ok) begin
        state_d   = st_b;
        aw_done_d = 1'b0;
        w_done_d  = 1'b0;
      end else begin
        state_d   = st_aw_w;
        aw_done_d = aw_ok;
        w_done_d  = w_ok;
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= st_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
    end
  end

endmodule

//--- execute_reg.sv
`timescale 1ns/10ps

module execute_reg import exu_pkg::*; (
  input  logic     clock,
  input  logic     arst_n_i,

  input  logic     we_i,
  input  exu_req_t req_i,
  output exu_req_t q_o
);

  // Holds the instruction until write-back takes the result
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      q_o <= '0;
    end else if (we_i) begin
      q_o <= req_i;
    end
  end

endmodule

//--- execute_sva.sv
`timescale 1ns/10ps

module execute_sva import exu_pkg::*; (
  input logic              clock,
  input logic              arst_n_i,
  input logic              ready_pre_o,
  input logic              valid_post_o,
  input logic              ready_post_i,
  input exu_res_t          res_o,
  input logic              awvalid_o,
  input logic              awready_i,
  input logic [xlen-1:0]   awaddr_o,
  input logic              wvalid_o,
  input logic              wready_i,
  input logic [xlen-1:0]   wdata_o,
  input logic [strb_w-1:0] wstrb_o,
  input logic              arvalid_o,
  input logic              arready_i,
  input logic [xlen-1:0]   araddr_o,
  input logic              bready_o,
  input logic              rready_o
);

  // Valid and payload hold until accepted
  post_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
    valid_post_o && !ready_post_i |=> valid_post_o && $stable(res_o))
    else $error("valid_post_o or res_o changed before the transfer");

  aw_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
    else $error("awvalid_o or awaddr_o changed before the transfer");

  w_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
    wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o))
    else $error("wvalid_o or the write data changed before the transfer");

  ar_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else $error("arvalid_o or araddr_o changed before the transfer");

  in_reset: assert property (@(posedge clock) !arst_n_i |-> ready_pre_o && !valid_post_o &&
    !awvalid_o && !wvalid_o && !arvalid_o && !bready_o && !rready_o)
    else $error("handshake outputs not idle during reset");

endmodule

bind execute execute_sva sva (.*);

//--- exu_pkg.sv
package exu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;
  localparam int strb_w     = xlen / 8;
  localparam int resp_w     = 2;

  typedef enum logic [2:0] {
    inst_alu_r,
    inst_alu_i,
    inst_lui,
    inst_auipc,
    inst_jump,
    inst_csr,
    inst_load,
    inst_store
  } inst_type_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  typedef enum logic [3:0] {
    lsu_none,
    lsu_lb,
    lsu_lbu,
    lsu_lh,
    lsu_lhu,
    lsu_lw,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_e;

  typedef enum logic [1:0] {
    csr_none,
    csr_rw,
    csr_rs,
    csr_rc
  } csr_op_e;

  // Decoded instruction from the decode stage
  typedef struct packed {
    inst_type_e             inst_type;
    alu_op_e                alu_op;
    lsu_op_e                lsu_op;
    csr_op_e                csr_op;
    logic                   wsel;
    logic                   wena;
    logic [reg_addr_w-1:0]  waddr;
    logic                   csr_wena;
    logic [csr_addr_w-1:0]  csr_waddr;
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        imm;
    logic [xlen-1:0]        rdata1;
    logic [xlen-1:0]        rdata2;
    logic [xlen-1:0]        csr_rdata;
  } exu_req_t;

  // Result and write-back controls
  typedef struct packed {
    logic                   wsel;
    logic                   wena;
    logic [reg_addr_w-1:0]  waddr;
    logic [xlen-1:0]        alu_result;
    logic [xlen-1:0]        mem_result;
    csr_op_e                csr_op;
    logic                   csr_wena;
    logic [csr_addr_w-1:0]  csr_waddr;
    logic [xlen-1:0]        csr_wdata;
  } exu_res_t;

endpackage

//--- fu.sv
`timescale 1ns/10ps

module fu import exu_pkg::*; (
  input  exu_req_t        req_i,
  output logic [xlen-1:0] alu_result_o,
  output logic [xlen-1:0] csr_wdata_o
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_out;

  assign op_a  = req_i.rdata1;
  assign op_b  = (req_i.inst_type == inst_alu_i) ? req_i.imm : req_i.rdata2;
  assign shamt = op_b[4:0];

  always_comb begin
    case (req_i.alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_and:  alu_out = op_a & op_b;
      alu_or:   alu_out = op_a | op_b;
      alu_xor:  alu_out = op_a ^ op_b;
      alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_sll:  alu_out = op_a << shamt;
      alu_srl:  alu_out = op_a >> shamt;
      alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
      default:  alu_out = '0;
    endcase
  end

  always_comb begin
    case (req_i.inst_type)
      inst_lui:   alu_result_o = req_i.imm;
      inst_auipc: alu_result_o = req_i.pc + req_i.imm;
      // Link value for jal and jalr
      inst_jump:  alu_result_o = req_i.pc + xlen'(4);
      inst_csr:   alu_result_o = req_i.csr_rdata;
      default:    alu_result_o = alu_out;
    endcase
  end

  always_comb begin
    case (req_i.csr_op)
      csr_rw:  csr_wdata_o = req_i.rdata1;
      csr_rs:  csr_wdata_o = req_i.csr_rdata | req_i.rdata1;
      csr_rc:  csr_wdata_o = req_i.csr_rdata & ~req_i.rdata1;
      default: csr_wdata_o = '0;
    endcase
  end

endmodule

//--- lsu.sv
`timescale 1ns/10ps

module lsu import exu_pkg::*; (
  input  logic              clock,
  input  logic              arst_n_i,

  input  logic              rdata_we_i,
  input  exu_req_t          req_i,

  output logic [xlen-1:0]   awaddr_o,
  output logic [xlen-1:0]   araddr_o,
  output logic [xlen-1:0]   wdata_o,
  output logic [strb_w-1:0] wstrb_o,
  output logic              wlast_o,
  input  logic [xlen-1:0]   rdata_i,

  output logic [xlen-1:0]   mem_result_o
);

  logic [xlen-1:0] addr;
  logic [1:0]      boff;
  logic [xlen-1:0] rdata_q;
  logic [xlen-1:0] lane;

  assign addr     = req_i.rdata1 + req_i.imm;
  assign boff     = addr[1:0];
  assign awaddr_o = {addr[xlen-1:2], 2'b00};
  assign araddr_o = {addr[xlen-1:2], 2'b00};

  // Single beat transfers only
  assign wlast_o = 1'b1;

  always_comb begin
    case (req_i.lsu_op)
      lsu_sb: begin
        wdata_o = {(xlen/8){req_i.rdata2[7:0]}};
        wstrb_o = strb_w'(4'b0001) << boff;
      end
      lsu_sh: begin
        wdata_o = {(xlen/16){req_i.rdata2[15:0]}};
        wstrb_o = strb_w'(4'b0011) << boff;
      end
      lsu_sw: begin
        wdata_o = req_i.rdata2;
        wstrb_o = '1;
      end
      default: begin
        wdata_o = req_i.rdata2;
        wstrb_o = '0;
      end
    endcase
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (rdata_we_i) begin
      rdata_q <= rdata_i;
    end
  end

  // Byte lane moved down to bit 0
  assign lane = rdata_q >> {boff, 3'b000};

  always_comb begin
    case (req_i.lsu_op)
      lsu_lb:  mem_result_o = {{(xlen-8){lane[7]}}, lane[7:0]};
      lsu_lbu: mem_result_o = {{(xlen-8){1'b0}}, lane[7:0]};
      lsu_lh:  mem_result_o = {{(xlen-16){lane[15]}}, lane[15:0]};
      lsu_lhu: mem_result_o = {{(xlen-16){1'b0}}, lane[15:0]};
      lsu_lw:  mem_result_o = rdata_q;
      default: mem_result_o = '0;
    endcase
  end

endmodule

//--- run_verilator.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_execute -f verilog.f -o sim_execute
./obj_dir/sim_execute | tee sim.log
if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- tb_execute.sv
`timescale 1ns/10ps

module tb_execute import exu_pkg::*; ();

  localparam int num_tests  = 26;
  localparam int max_cycles = num_tests * 20 + 100;

  typedef struct packed {
    exu_req_t          req;
    logic [xlen-1:0]   rword;
    logic [xlen-1:0]   exp_alu;
    logic [xlen-1:0]   exp_csr;
    logic [xlen-1:0]   exp_mem;
    logic [xlen-1:0]   exp_addr;
    logic [xlen-1:0]   exp_wdata;
    logic [strb_w-1:0] exp_wstrb;
  } vec_t;

  logic              clock;
  logic              arst_n_i;
  logic              valid_pre_i;
  logic              ready_pre_o;
  exu_req_t          req_i;
  logic              valid_post_o;
  logic              ready_post_i;
  exu_res_t          res_o;
  logic              awvalid_o;
  logic              awready_i;
  logic [xlen-1:0]   awaddr_o;
  logic              wvalid_o;
  logic              wready_i;
  logic [xlen-1:0]   wdata_o;
  logic [strb_w-1:0] wstrb_o;
  logic              wlast_o;
  logic              bvalid_i;
  logic              bready_o;
  logic [resp_w-1:0] bresp_i;
  logic              arvalid_o;
  logic              arready_i;
  logic [xlen-1:0]   araddr_o;
  logic              rvalid_i;
  logic              rready_o;
  logic [xlen-1:0]   rdata_i;
  logic [resp_w-1:0] rresp_i;
  logic              rlast_i;

  vec_t              tbl [num_tests];
  int                n_entries = 0;
  integer            seed = 58001;
  int                errors = 0;
  int                checks = 0;
  int                cur = 0;
  int                cycle_cnt = 0;
  logic [xlen-1:0]   rword;
  // Transfers seen by the AXI slave over the whole run
  int                aw_cnt;
  int                w_cnt;
  int                b_cnt;
  int                ar_cnt;
  int                r_cnt;
  int                post_cnt;
  int                aw_wait;
  int                w_wait;
  int                ar_wait;
  logic [xlen-1:0]   aw_addr;
  logic [xlen-1:0]   w_data;
  logic [strb_w-1:0] w_strb;
  logic              w_last;
  logic [xlen-1:0]   ar_addr;

  execute uut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic int rand_delay();
    return $random(seed) & 3;
  endfunction

  task automatic check_value(input string name, input logic [xlen-1:0] exp,
                             input logic [xlen-1:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("Entry %0d at %0t: %s", cur, $time, msg);
      errors++;
    end
  endtask

  task automatic add_entry(
    input inst_type_e        t,
    input alu_op_e           a,
    input lsu_op_e           l,
    input csr_op_e           c,
    input logic [xlen-1:0]   imm, r1, r2, csrd,
    input logic [xlen-1:0]   rword_v, e_alu, e_csr, e_mem, e_addr, e_wdata,
    input logic [strb_w-1:0] e_strb
  );
    exu_req_t r;
    r           = '0;
    r.inst_type = t;
    r.alu_op    = a;
    r.lsu_op    = l;
    r.csr_op    = c;
    r.wsel      = (t == inst_load);
    r.wena      = (t != inst_store);
    r.waddr     = reg_addr_w'(n_entries + 1);
    r.csr_wena  = (c != csr_none);
    r.csr_waddr = csr_addr_w'(n_entries + 'h300);
    r.pc        = xlen'(32'h1000 + n_entries * 4);
    r.imm       = imm;
    r.rdata1    = r1;
    r.rdata2    = r2;
    r.csr_rdata = csrd;
    tbl[n_entries] = '{r, rword_v, e_alu, e_csr, e_mem, e_addr, e_wdata, e_strb};
    n_entries++;
  endtask

  // Operands are imm, rdata1, rdata2 and csr_rdata
  // Then R word, alu_result, csr_wdata, mem_result, address, wdata and wstrb
  task automatic build_table();
    add_entry(inst_alu_r, alu_add, lsu_none, csr_none, 'h0, 'h5, 'hffff_fffd, 'h0,
              'h0, 'h2, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_r, alu_sub, lsu_none, csr_none, 'h0, 'h3, 'h5, 'h0,
              'h0, 'hffff_fffe, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_i, alu_and, lsu_none, csr_none, 'hff0, 'hf0f0_1234, 'hffff_ffff, 'h0,
              'h0, 'h230, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_i, alu_or, lsu_none, csr_none, 'h34, 'h1200_0000, 'h0, 'h0,
              'h0, 'h1200_0034, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_r, alu_xor, lsu_none, csr_none, 'h0, 'haaaa_5555, 'hffff_0000, 'h0,
              'h0, 'h5555_5555, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_r, alu_slt, lsu_none, csr_none, 'h0, 'hffff_ffff, 'h1, 'h0,
              'h0, 'h1, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_r, alu_sltu, lsu_none, csr_none, 'h0, 'hffff_ffff, 'h1, 'h0,
              'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 4'h0);
    // Shift amount 0x24 keeps only its low 5 bits
    add_entry(inst_alu_i, alu_sll, lsu_none, csr_none, 'h24, 'h3, 'h0, 'h0,
              'h0, 'h30, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_r, alu_srl, lsu_none, csr_none, 'h0, 'h8000_0000, 'h4, 'h0,
              'h0, 'h0800_0000, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_alu_i, alu_sra, lsu_none, csr_none, 'h4, 'h8000_0000, 'h0, 'h0,
              'h0, 'hf800_0000, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_lui, alu_add, lsu_none, csr_none, 'h1234_5000, 'h5555_5555, 'h0, 'h0,
              'h0, 'h1234_5000, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_auipc, alu_add, lsu_none, csr_none, 'h2000, 'h0, 'h0, 'h0,
              'h0, 'h302c, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_jump, alu_add, lsu_none, csr_none, 'h40, 'h0, 'h0, 'h0,
              'h0, 'h1034, 'h0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_csr, alu_add, lsu_none, csr_rw, 'h0, 'hf, 'h0, 'hf0,
              'h0, 'hf0, 'hf, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_csr, alu_add, lsu_none, csr_rs, 'h0, 'h11, 'h0, 'h1100,
              'h0, 'h1100, 'h1111, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_csr, alu_add, lsu_none, csr_rc, 'h0, 'hf0f, 'h0, 'hffff,
              'h0, 'hffff, 'hf0f0, 'h0, 'h0, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lb, csr_none, 'h0, 'h2000_0000, 'h0, 'h0,
              'h84f2_7a91, 'h0, 'h0, 'hffff_ff91, 'h2000_0000, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lbu, csr_none, 'h1, 'h2000_0100, 'h0, 'h0,
              'h84f2_7a91, 'h0, 'h0, 'h7a, 'h2000_0100, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lb, csr_none, 'hffff_fffc, 'h2000_0206, 'h0, 'h0,
              'h84f2_7a91, 'h0, 'h0, 'hffff_fff2, 'h2000_0200, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lbu, csr_none, 'h3, 'h2000_0300, 'h0, 'h0,
              'h84f2_7a91, 'h0, 'h0, 'h84, 'h2000_0300, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lh, csr_none, 'h0, 'h2000_0400, 'h0, 'h0,
              'h1234_9abc, 'h0, 'h0, 'hffff_9abc, 'h2000_0400, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lhu, csr_none, 'h2, 'h2000_0500, 'h0, 'h0,
              'hc001_5678, 'h0, 'h0, 'hc001, 'h2000_0500, 'h0, 4'h0);
    add_entry(inst_load, alu_add, lsu_lw, csr_none, 'h4, 'h2000_0600, 'h0, 'h0,
              'hdead_beef, 'h0, 'h0, 'hdead_beef, 'h2000_0604, 'h0, 4'h0);
    add_entry(inst_store, alu_add, lsu_sb, csr_none, 'h3, 'h3000_0000, 'hcafe_f00d, 'h0,
              'h0, 'h0, 'h0, 'h0, 'h3000_0000, 'h0d0d_0d0d, 4'h8);
    add_entry(inst_store, alu_add, lsu_sh, csr_none, 'h2, 'h3000_0010, 'hcafe_f00d, 'h0,
              'h0, 'h0, 'h0, 'h0, 'h3000_0010, 'hf00d_f00d, 4'hc);
    add_entry(inst_store, alu_add, lsu_sw, csr_none, 'h8, 'h3000_0020, 'hcafe_f00d, 'h0,
              'h0, 'h0, 'h0, 'h0, 'h3000_0028, 'hcafe_f00d, 4'hf);
  endtask

  task automatic check_result(input vec_t v);
    inst_type_e t;
    t = v.req.inst_type;
    check_value("res_o.wsel", 32'(v.req.wsel), 32'(res_o.wsel));
    check_value("res_o.wena", 32'(v.req.wena), 32'(res_o.wena));
    check_value("res_o.waddr", 32'(v.req.waddr), 32'(res_o.waddr));
    check_value("res_o.csr_op", 32'(v.req.csr_op), 32'(res_o.csr_op));
    check_value("res_o.csr_wena", 32'(v.req.csr_wena), 32'(res_o.csr_wena));
    check_value("res_o.csr_waddr", 32'(v.req.csr_waddr), 32'(res_o.csr_waddr));
    if (t != inst_load && t != inst_store) begin
      check_value("res_o.alu_result", v.exp_alu, res_o.alu_result);
    end
    if (t == inst_csr) begin
      check_value("res_o.csr_wdata", v.exp_csr, res_o.csr_wdata);
    end
    if (t == inst_load) begin
      check_value("res_o.mem_result", v.exp_mem, res_o.mem_result);
    end
  endtask

  // AXI slave with random ready delays
  initial begin : axi_slave
    awready_i = 1'b0;
    wready_i  = 1'b0;
    bvalid_i  = 1'b0;
    bresp_i   = '0;
    arready_i = 1'b0;
    rvalid_i  = 1'b0;
    rdata_i   = '0;
    rresp_i   = '0;
    rlast_i   = 1'b1;
    aw_cnt    = 0;
    w_cnt     = 0;
    b_cnt     = 0;
    ar_cnt    = 0;
    r_cnt     = 0;
    post_cnt  = 0;
    aw_wait   = rand_delay();
    w_wait    = rand_delay();
    ar_wait   = rand_delay();
    forever begin
      @(posedge clock);
      if (arst_n_i) begin
        if (awvalid_o && awready_i) begin
          aw_cnt++;
          aw_addr = awaddr_o;
          aw_wait = rand_delay();
        end
        if (wvalid_o && wready_i) begin
          w_cnt++;
          w_data  = wdata_o;
          w_strb  = wstrb_o;
          w_last  = wlast_o;
          w_wait  = rand_delay();
        end
        if (arvalid_o && arready_i) begin
          ar_cnt++;
          ar_addr = araddr_o;
          ar_wait = rand_delay();
        end
        if (bvalid_i && bready_o) b_cnt++;
        if (rvalid_i && rready_o) r_cnt++;
        if (valid_post_o && ready_post_i) post_cnt++;
      end
      @(negedge clock);
      if (arst_n_i) begin
        awready_i = awvalid_o && (aw_wait == 0);
        wready_i  = wvalid_o && (w_wait == 0);
        arready_i = arvalid_o && (ar_wait == 0);
        if (awvalid_o && aw_wait != 0) aw_wait--;
        if (wvalid_o && w_wait != 0) w_wait--;
        if (arvalid_o && ar_wait != 0) ar_wait--;
        // Response once both halves of the write are in
        bvalid_i  = (aw_cnt > b_cnt) && (w_cnt > b_cnt);
        rvalid_i  = (ar_cnt > r_cnt);
        rdata_i   = rword;
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < max_cycles) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, entry %0d did not complete", cycle_cnt, cur);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int       lat;
    int       stall;
    int       errs_before;
    int       exp_writes;
    int       exp_reads;
    logic     is_load;
    logic     is_store;
    exu_res_t snap;
    arst_n_i     = 1'b0;
    valid_pre_i  = 1'b0;
    req_i        = '0;
    ready_post_i = 1'b0;
    rword        = '0;
    exp_writes   = 0;
    exp_reads    = 0;
    build_table();
    repeat (8) @(negedge clock);
    arst_n_i = 1'b1;
    for (int i = 0; i < num_tests; i++) begin
      cur         = i;
      errs_before = errors;
      is_load     = (tbl[i].req.inst_type == inst_load);
      is_store    = (tbl[i].req.inst_type == inst_store);
      rword       = tbl[i].rword;
      req_i       = tbl[i].req;
      valid_pre_i = 1'b1;
      do @(posedge clock); while (!ready_pre_o);
      @(negedge clock);
      valid_pre_i = 1'b0;
      req_i       = '1;
      lat         = 0;
      do begin
        @(posedge clock);
        lat++;
        check_true(!ready_pre_o, "ready_pre_o high while an instruction was in flight");
      end while (!valid_post_o);
      if (!is_load && !is_store) begin
        check_true(lat == 1, "valid_post_o did not rise one cycle after acceptance");
      end
      snap  = res_o;
      stall = rand_delay();
      repeat (stall) begin
        @(posedge clock);
        check_true(valid_post_o && (res_o === snap), "result changed during a stall");
      end
      @(negedge clock);
      ready_post_i = 1'b1;
      @(posedge clock);
      check_true(valid_post_o, "valid_post_o dropped before the transfer");
      check_true(ready_pre_o, "ready_pre_o low during the downstream transfer");
      check_result(tbl[i]);
      @(negedge clock);
      ready_post_i = 1'b0;
      if (is_store) begin
        exp_writes++;
        check_value("awaddr_o", tbl[i].exp_addr, aw_addr);
        check_value("wdata_o", tbl[i].exp_wdata, w_data);
        check_value("wstrb_o", 32'(tbl[i].exp_wstrb), 32'(w_strb));
        check_value("wlast_o", 32'(1'b1), 32'(w_last));
      end
      if (is_load) begin
        exp_reads++;
        check_value("araddr_o", tbl[i].exp_addr, ar_addr);
      end
      check_true(aw_cnt == exp_writes && w_cnt == exp_writes && b_cnt == exp_writes,
                 "write transfers do not match the stores so far");
      check_true(ar_cnt == exp_reads && r_cnt == exp_reads,
                 "read transfers do not match the loads so far");
      check_true(post_cnt == i + 1, "results completed out of step with the entries");
      $display("Entry %0d: %s", i, (errors == errs_before) ? "ok" : "errors");
    end
    $display("%0d entries, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
exu_pkg.sv
execute_reg.sv
execute_controller.sv
fu.sv
lsu.sv
execute.sv
execute_sva.sv
tb_execute.sv
